// File: Bender.yml
package:
  name: csr_unit

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/csr_pkg.sv
      - verilog/csr_port_if.sv
      - verilog/csr_op_decode.sv
      - verilog/csr_regfile.sv
      - verilog/csr_ctrl.sv
      - verilog/csr_unit.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/csr_unit_asserts.sv
      - bench/csr_unit_tb.sv

// File: bench/csr_unit_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module csr_ctrl_asserts import csr_pkg::*; (
  input logic        clk,
  input logic        rst,
  input logic        req,
  input logic        ack,
  input ctrl_state_e state,
  input logic        wen,
  input logic        trap_enter,
  input logic        trap_return
);

  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(ack) |-> $past(req))
    else $error("ack rose without a request");

  // return to zero.
  ack_falls_after_req: assert property (@(posedge clk) disable iff (rst)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

  strobes_onehot: assert property (@(posedge clk) disable iff (rst)
    $onehot0({wen, trap_enter, trap_return}))
    else $error("more than one register file strobe active");

  strobes_in_exec: assert property (@(posedge clk) disable iff (rst)
    (wen || trap_enter || trap_return) |-> (state == EXEC))
    else $error("register file strobe outside EXEC");

  ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack)
    else $error("ack high after a reset cycle");

endmodule

bind csr_ctrl csr_ctrl_asserts u_asserts (
  .clk         (clk),
  .rst         (rst),
  .req         (req),
  .ack         (ack),
  .state       (state),
  .wen         (port.wen),
  .trap_enter  (port.trap_enter),
  .trap_return (port.trap_return)
);

`default_nettype wire

// File: bench/csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_map.svh"

module csr_unit_tb import csr_pkg::*; ();

  localparam word_t       MTVEC_RST   = 32'h0000_0180;
  localparam int          NUM_VECS    = 33;
  localparam int          ACK_TIMEOUT = 20;
  localparam logic [31:0] LFSR_SEED   = 32'ha609_11bb;

  typedef struct packed {
    csr_op_e   op;
    csr_addr_t addr;
    word_t     src;
    word_t     pc;
    word_t     exp_rdata;
    logic      exp_illegal;
    logic      exp_redirect;
    word_t     exp_target;
  } vec_t;

  // op, addr, src, pc, then expected rdata, illegal, redirect, target.
  localparam vec_t VECS [NUM_VECS] = '{
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MEPC, 32'h0, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MTVEC, 32'h0, 32'h0, MTVEC_RST, 1'b0, 1'b0, 32'h0},
    '{CSR_RW, `CSR_ADDR_MCAUSE, 32'h1234_5678, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0000_00f0, 32'h0, 32'h1234_5678, 1'b0, 1'b0, 32'h0},
    '{CSR_RC, `CSR_ADDR_MCAUSE, 32'h0000_0078, 32'h0, 32'h1234_56f8, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0, 32'h0, 32'h1234_5680, 1'b0, 1'b0, 32'h0},
    '{CSR_RW, `CSR_ADDR_MTVEC, 32'h8000_0040, 32'h0, MTVEC_RST, 1'b0, 1'b0, 32'h0},
    '{CSR_RC, `CSR_ADDR_MTVEC, 32'h0000_0040, 32'h0, 32'h8000_0040, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MTVEC, 32'h0000_0200, 32'h0, 32'h8000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MTVEC, 32'h0, 32'h0, 32'h8000_0200, 1'b0, 1'b0, 32'h0},
    '{CSR_RW, `CSR_ADDR_MSTATUS, 32'hffff_ffff, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0, 32'h0, 32'h0000_0088, 1'b0, 1'b0, 32'h0},
    '{CSR_RC, `CSR_ADDR_MSTATUS, 32'hffff_ffff, 32'h0, 32'h0000_0088, 1'b0, 1'b0, 32'h0},
    '{CSR_RW, `CSR_ADDR_MEPC, 32'h0000_1237, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MEPC, 32'h0, 32'h0, 32'h0000_1234, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0000_0008, 32'h0, 32'h0000_0000, 1'b0, 1'b0, 32'h0},
    '{CSR_ECALL, 12'h000, 32'h0, 32'h0000_2468, 32'h0, 1'b0, 1'b1, 32'h8000_0200},
    '{CSR_RS, `CSR_ADDR_MEPC, 32'h0, 32'h0, 32'h0000_2468, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0, 32'h0, 32'h0000_000b, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0, 32'h0, 32'h0000_0080, 1'b0, 1'b0, 32'h0},
    '{CSR_MRET, 12'h000, 32'h0, 32'h0, 32'h0, 1'b0, 1'b1, 32'h0000_2468},
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0, 32'h0, 32'h0000_0088, 1'b0, 1'b0, 32'h0},
    '{CSR_RW, 12'h7c0, 32'h0000_0000, 32'h0, 32'h0000_0000, 1'b1, 1'b0, 32'h0},
    '{CSR_RW, `CSR_ADDR_MVENDORID, 32'h1, 32'h0, `MVENDORID_VAL, 1'b1, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MARCHID, 32'h0, 32'h0, `MARCHID_VAL, 1'b0, 1'b0, 32'h0},
    '{CSR_RC, `CSR_ADDR_MVENDORID, 32'h1, 32'h0, `MVENDORID_VAL, 1'b1, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MSTATUS, 32'h0, 32'h0, 32'h0000_0088, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MVENDORID, 32'h0, 32'h0, `MVENDORID_VAL, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0000_0100, 32'h0, 32'h0000_000b, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0000_0200, 32'h0, 32'h0000_010b, 1'b0, 1'b0, 32'h0},
    '{CSR_RS, `CSR_ADDR_MCAUSE, 32'h0, 32'h0, 32'h0000_030b, 1'b0, 1'b0, 32'h0}
  };

  logic      clk;
  logic      rst;
  logic      req;
  csr_op_e   op;
  csr_addr_t addr;
  word_t     src;
  word_t     pc;
  logic      ack;
  word_t     rdata;
  logic      illegal;
  logic      redirect;
  word_t     target;

  logic [31:0] lfsr;
  int checks;
  int errors;
  int timeouts;

  csr_unit #(
    .RESET_MTVEC (MTVEC_RST)
  ) uut (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .op       (op),
    .addr     (addr),
    .src      (src),
    .pc       (pc),
    .ack      (ack),
    .rdata    (rdata),
    .illegal  (illegal),
    .redirect (redirect),
    .target   (target)
  );

  always #50 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit.
  function automatic int rand_bits(input int n);
    int val;
    val = 0;
    for (int i = 0; i < n; i++) begin
      val  = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_next(lfsr);
    end
    return val;
  endfunction

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAILED %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_outputs(input int n);
    if (VECS[n].op != CSR_ECALL && VECS[n].op != CSR_MRET) begin
      check_val("rdata", VECS[n].exp_rdata, rdata);
    end
    check_val("illegal", 32'(VECS[n].exp_illegal), 32'(illegal));
    check_val("redirect", 32'(VECS[n].exp_redirect), 32'(redirect));
    if (VECS[n].exp_redirect) begin
      check_val("target", VECS[n].exp_target, target);
    end
  endtask

  task automatic wait_ack(input logic level, input int n);
    int cnt;
    cnt = 0;
    while (ack !== level && cnt < ACK_TIMEOUT) begin
      @(posedge clk);
      #10;
      cnt++;
    end
    if (ack !== level) begin
      timeouts++;
      $display("timeout waiting for ack to become %0d on entry %0d", level, n);
    end
  endtask

  task automatic run_vec(input int n);
    int hold;
    int idle;
    op   = VECS[n].op;
    addr = VECS[n].addr;
    src  = VECS[n].src;
    pc   = VECS[n].pc;
    req  = 1'b1;
    wait_ack(1'b1, n);
    if (timeouts == 0) begin
      check_outputs(n);
      hold = rand_bits(2);
      repeat (hold) begin  // back-pressure, outputs must hold.
        @(posedge clk);
        #10;
        check_val("ack", 32'h1, 32'(ack));
        check_outputs(n);
      end
      req = 1'b0;
      wait_ack(1'b0, n);
      idle = rand_bits(2) % 3;
      repeat (idle) begin
        @(posedge clk);
        #10;
      end
    end
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    req      = 1'b0;
    op       = CSR_RS;
    addr     = '0;
    src      = '0;
    pc       = '0;
    lfsr     = LFSR_SEED;
    checks   = 0;
    errors   = 0;
    timeouts = 0;
    repeat (3) @(posedge clk);
    #10;
    rst = 1'b0;
    check_val("ack", 32'h0, 32'(ack));
    check_val("illegal", 32'h0, 32'(illegal));
    check_val("redirect", 32'h0, 32'(redirect));
    for (int i = 0; i < NUM_VECS && timeouts == 0; i++) begin
      run_vec(i);
    end
    $display("%0d checks, %0d value errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: include/csr_map.svh
`ifndef CSR_MAP_SVH
`define CSR_MAP_SVH

// machine-level csr addresses.
`define CSR_ADDR_MSTATUS   12'h300
`define CSR_ADDR_MTVEC     12'h305
`define CSR_ADDR_MEPC      12'h341
`define CSR_ADDR_MCAUSE    12'h342
`define CSR_ADDR_MVENDORID 12'hf11
`define CSR_ADDR_MARCHID   12'hf12

// top two address bits set means read-only.
`define CSR_ADDR_RO_FIELD  2'b11

// mstatus fields that are implemented.
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7

// id register contents.
`define MVENDORID_VAL 32'h7973_7978
`define MARCHID_VAL   32'h015f_de77

`endif

// File: list.f
+incdir+include
verilog/csr_pkg.sv
verilog/csr_port_if.sv
verilog/csr_op_decode.sv
verilog/csr_regfile.sv
verilog/csr_ctrl.sv
verilog/csr_unit.sv
bench/csr_unit_asserts.sv
bench/csr_unit_tb.sv

// File: verilog/csr_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module csr_ctrl import csr_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  csr_op_e   op,
  input  csr_addr_t addr,
  input  word_t     src,
  input  word_t     pc,
  output logic      ack,
  output word_t     rdata,
  output logic      illegal,
  output logic      redirect,
  output word_t     target,
  csr_port_if.ctrl  port
);

  ctrl_state_e state;

  csr_op_e   op_q;
  csr_addr_t addr_q;
  word_t     src_q;
  word_t     pc_q;

  csr_idx_e dec_idx;
  logic     dec_hit;
  logic     dec_ro;
  word_t    dec_new;
  logic     ro_write;

  logic  nxt_illegal;
  logic  nxt_redirect;
  word_t nxt_rdata;
  word_t nxt_target;

  csr_op_decode u_dec (
    .op        (op_q),
    .addr      (addr_q),
    .old       (port.rd_data),
    .src       (src_q),
    .idx       (dec_idx),
    .hit       (dec_hit),
    .read_only (dec_ro),
    .new_val   (dec_new)
  );

  // rs/rc with zero source only read.
  assign ro_write = dec_ro && ((op_q == CSR_RW) || (src_q != '0));

  always_comb begin
    port.rd_idx      = dec_idx;
    port.wr_idx      = dec_idx;
    port.wr_data     = dec_new;
    port.epc         = pc_q;
    port.wen         = 1'b0;
    port.trap_enter  = 1'b0;
    port.trap_return = 1'b0;
    nxt_rdata        = '0;
    nxt_illegal      = 1'b0;
    nxt_redirect     = 1'b0;
    nxt_target       = '0;
    if (state == EXEC) begin
      case (op_q)
        CSR_RW, CSR_RS, CSR_RC: begin
          if (!dec_hit) begin
            nxt_illegal = 1'b1;  // unknown csr reads as zero.
          end else begin
            nxt_rdata = port.rd_data;
            if (ro_write) begin
              nxt_illegal = 1'b1;
            end else begin
              port.wen = 1'b1;
            end
          end
        end
        CSR_ECALL: begin
          port.trap_enter = 1'b1;
          nxt_redirect    = 1'b1;
          nxt_target      = port.mtvec;
        end
        CSR_MRET: begin
          port.trap_return = 1'b1;
          nxt_redirect     = 1'b1;
          nxt_target       = port.mepc;
        end
        default: begin
          nxt_illegal = 1'b1;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= IDLE;
      ack      <= 1'b0;
      illegal  <= 1'b0;
      redirect <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (req) state <= EXEC;
        end
        EXEC: begin
          state    <= DONE;
          ack      <= 1'b1;
          illegal  <= nxt_illegal;
          redirect <= nxt_redirect;
        end
        DONE: begin
          if (!req) begin  // four-phase return to zero.
            state <= IDLE;
            ack   <= 1'b0;
          end
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // request latch and result data.
  always_ff @(posedge clk) begin
    if (state == IDLE && req) begin
      op_q   <= op;
      addr_q <= addr;
      src_q  <= src;
      pc_q   <= pc;
    end
    if (state == EXEC) begin
      rdata  <= nxt_rdata;
      target <= nxt_target;
    end
  end

endmodule

`default_nettype wire

// File: verilog/csr_op_decode.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_map.svh"

module csr_op_decode import csr_pkg::*; (
  input  csr_op_e   op,
  input  csr_addr_t addr,
  input  word_t     old,
  input  word_t     src,
  output csr_idx_e  idx,
  output logic      hit,
  output logic      read_only,
  output word_t     new_val
);

  // address map.
  always_comb begin
    idx = IDX_MSTATUS;
    hit = 1'b1;
    case (addr)
      `CSR_ADDR_MSTATUS: begin
        idx = IDX_MSTATUS;
      end
      `CSR_ADDR_MEPC: begin
        idx = IDX_MEPC;
      end
      `CSR_ADDR_MCAUSE: begin
        idx = IDX_MCAUSE;
      end
      `CSR_ADDR_MTVEC: begin
        idx = IDX_MTVEC;
      end
      `CSR_ADDR_MVENDORID: begin
        idx = IDX_MVENDORID;
      end
      `CSR_ADDR_MARCHID: begin
        idx = IDX_MARCHID;
      end
      default: begin
        hit = 1'b0;
      end
    endcase
  end

  // privileged spec encodes read-only in the top address bits.
  assign read_only = (addr[11:10] == `CSR_ADDR_RO_FIELD);

  // value to write back.
  always_comb begin
    case (op)
      CSR_RW: begin
        new_val = src;
      end
      CSR_RS: begin
        new_val = old | src;
      end
      CSR_RC: begin
        new_val = old & ~src;
      end
      default: begin
        new_val = old;  // trap ops do not write through here.
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/csr_pkg.sv
`default_nettype none
`include "csr_map.svh"

package csr_pkg;

  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [11:0]     csr_addr_t;

  typedef enum logic [2:0] {
    CSR_RW,
    CSR_RS,
    CSR_RC,
    CSR_ECALL,
    CSR_MRET
  } csr_op_e;

  typedef enum logic [2:0] {
    IDX_MSTATUS,
    IDX_MEPC,
    IDX_MCAUSE,
    IDX_MTVEC,
    IDX_MVENDORID,
    IDX_MARCHID
  } csr_idx_e;

  typedef enum logic [1:0] {
    IDLE,
    EXEC,
    DONE
  } ctrl_state_e;

  localparam word_t CAUSE_ECALL_M = 32'd11; // environment call from m-mode.

  // only mie and mpie survive a write.
  localparam word_t MSTATUS_WMASK = (word_t'(1) << `MSTATUS_MIE_BIT) |
                                    (word_t'(1) << `MSTATUS_MPIE_BIT);

endpackage

`default_nettype wire

// File: verilog/csr_port_if.sv
`timescale 1ns/10ps
`default_nettype none

interface csr_port_if import csr_pkg::*; ();

  csr_idx_e rd_idx;
  logic     wen;
  csr_idx_e wr_idx;
  word_t    wr_data;
  logic     trap_enter;
  logic     trap_return;
  word_t    epc;

  word_t    rd_data;  // combinational read of rd_idx.
  word_t    mepc;
  word_t    mtvec;

  modport ctrl (
    output rd_idx, wen, wr_idx, wr_data,
    output trap_enter, trap_return, epc,
    input  rd_data, mepc, mtvec
  );

  modport regs (
    input  rd_idx, wen, wr_idx, wr_data,
    input  trap_enter, trap_return, epc,
    output rd_data, mepc, mtvec
  );

endinterface

`default_nettype wire

// File: verilog/csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none
`include "csr_map.svh"

module csr_regfile import csr_pkg::*; #(
  parameter word_t RESET_MTVEC = 32'h0000_0100
) (
  input  logic     clk,
  input  logic     rst,
  csr_port_if.regs port
);

  word_t mstatus_q;
  word_t mepc_q;
  word_t mcause_q;
  word_t mtvec_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
      mtvec_q   <= RESET_MTVEC;
    end else if (port.trap_enter) begin
      mepc_q   <= {port.epc[XLEN-1:2], 2'b00};
      mcause_q <= CAUSE_ECALL_M;
      mstatus_q[`MSTATUS_MPIE_BIT] <= mstatus_q[`MSTATUS_MIE_BIT];
      mstatus_q[`MSTATUS_MIE_BIT]  <= 1'b0;  // interrupts off in handler.
    end else if (port.trap_return) begin
      mstatus_q[`MSTATUS_MIE_BIT]  <= mstatus_q[`MSTATUS_MPIE_BIT];
      mstatus_q[`MSTATUS_MPIE_BIT] <= 1'b1;
    end else if (port.wen) begin
      case (port.wr_idx)
        IDX_MSTATUS: begin
          mstatus_q <= port.wr_data & MSTATUS_WMASK;
        end
        IDX_MEPC: begin
          mepc_q <= {port.wr_data[XLEN-1:2], 2'b00};  // ialign 32.
        end
        IDX_MCAUSE: begin
          mcause_q <= port.wr_data;
        end
        IDX_MTVEC: begin
          mtvec_q <= port.wr_data;
        end
        default: begin
          // id registers keep their constants.
        end
      endcase
    end
  end

  // read mux.
  always_comb begin
    case (port.rd_idx)
      IDX_MSTATUS: begin
        port.rd_data = mstatus_q;
      end
      IDX_MEPC: begin
        port.rd_data = mepc_q;
      end
      IDX_MCAUSE: begin
        port.rd_data = mcause_q;
      end
      IDX_MTVEC: begin
        port.rd_data = mtvec_q;
      end
      IDX_MVENDORID: begin
        port.rd_data = `MVENDORID_VAL;
      end
      IDX_MARCHID: begin
        port.rd_data = `MARCHID_VAL;
      end
      default: begin
        port.rd_data = '0;
      end
    endcase
  end

  // redirect targets.
  assign port.mepc  = mepc_q;
  assign port.mtvec = mtvec_q;

endmodule

`default_nettype wire

// File: verilog/csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_unit import csr_pkg::*; #(
  parameter word_t RESET_MTVEC = 32'h0000_0100
) (
  input  logic      clk,
  input  logic      rst,
  input  logic      req,
  input  csr_op_e   op,
  input  csr_addr_t addr,
  input  word_t     src,
  input  word_t     pc,
  output logic      ack,
  output word_t     rdata,
  output logic      illegal,
  output logic      redirect,
  output word_t     target
);

  csr_port_if u_port ();

  // handshake and sequencing.
  csr_ctrl u_ctrl (
    .clk      (clk),
    .rst      (rst),
    .req      (req),
    .op       (op),
    .addr     (addr),
    .src      (src),
    .pc       (pc),
    .ack      (ack),
    .rdata    (rdata),
    .illegal  (illegal),
    .redirect (redirect),
    .target   (target),
    .port     (u_port.ctrl)
  );

  // csr storage.
  csr_regfile #(
    .RESET_MTVEC (RESET_MTVEC)
  ) u_regs (
    .clk  (clk),
    .rst  (rst),
    .port (u_port.regs)
  );

endmodule

`default_nettype wire
